// File: include/servo_settings.svh
/* Constants shared by the servo RTL and its testbench
   SERVO_PWM_PERIOD must stay below 128 so a duty fits servo_pkg::duty_t */
`ifndef SERVO_SETTINGS_SVH
`define SERVO_SETTINGS_SVH

// AS5600 device bytes and raw angle register pointer
`define SERVO_ENC_WRITE_ADDR 8'h6C
`define SERVO_ENC_READ_ADDR  8'h6D
`define SERVO_RAW_ANGLE_REG  8'h0C

`define SERVO_FIFO_DEPTH     4
`define SERVO_PWM_PERIOD     64   // Clock cycles per PWM period
`define SERVO_ANGLE_TOL      8    // Largest error in counts that is still on target
`define SERVO_DUTY_SHIFT     4

`endif

// File: hdl/servo_pkg.sv
/* Types for the servo position loop
   Angles are raw AS5600 counts, one turn is 4096 counts */
package servo_pkg;

    typedef logic [11:0] angle_t;
    typedef logic signed [12:0] angle_err_t;
    typedef logic [6:0] duty_t;   // 0 up to the PWM period

    // Order follows the I2C transaction, ABORT is the STOP after a missing ACK
    typedef enum logic [3:0] {
        IDLE, START, DEV_WR, ACK0,
        READ_ADDR, ACK1, REP_START, DEV_RD,
        ACK2, DATA0, ACK3, DATA1,
        NACK, STOP, PAUSE, ABORT
    } i2c_state_e;

endpackage

// File: hdl/as5600_reader.sv
/* I2C master that reads the AS5600 raw angle, one bit slot per 4 PHASE1 cycles
   sda is open drain and needs a pull-up outside, clock stretching is not supported
   A missing ACK ends the transfer with STOP and an i2c_error pulse */
`timescale 1ns/100ps
`include "servo_settings.svh"

module as5600_reader (
    input  logic              PHASE1,
    input  logic              reset_n,
    input  logic              angle_done,
    output servo_pkg::angle_t sample,
    output logic              rd_done,
    output logic              i2c_error,
    output logic              scl,
    inout  wire               sda
);

    servo_pkg::i2c_state_e state;
    servo_pkg::i2c_state_e state_next;
    logic [1:0]  quarter;
    logic        step;
    logic [2:0]  bit_cnt;
    logic        byte_state;
    logic        ack_state;
    logic        ack_fail;
    logic [11:0] data_sr;
    logic [7:0]  tx_byte;
    logic        tx_bit;
    logic        sda_low;

    assign step = (quarter == 2'd3);   // Last quarter of a slot

    assign byte_state = (state == servo_pkg::DEV_WR) || (state == servo_pkg::READ_ADDR) ||
                        (state == servo_pkg::DEV_RD) || (state == servo_pkg::DATA0) ||
                        (state == servo_pkg::DATA1);
    assign ack_state = (state == servo_pkg::ACK0) || (state == servo_pkg::ACK1) ||
                       (state == servo_pkg::ACK2);

    always_ff @(posedge PHASE1 or negedge reset_n) begin
        if (!reset_n) begin
            quarter   <= 2'd0;
            state     <= servo_pkg::IDLE;
            bit_cnt   <= 3'd0;
            ack_fail  <= 1'b0;
            rd_done   <= 1'b0;
            i2c_error <= 1'b0;
        end else begin
            quarter   <= quarter + 2'd1;
            rd_done   <= step && (state == servo_pkg::STOP);
            i2c_error <= step && (state == servo_pkg::ABORT);
            if (ack_state && (quarter == 2'd2)) begin
                ack_fail <= (sda != 1'b0);   // Released line means no target answered
            end
            if (step) begin
                state <= state_next;
                if (byte_state) begin
                    bit_cnt <= bit_cnt + 3'd1;   // Wraps to 0 after the eighth bit
                end else begin
                    bit_cnt <= 3'd0;
                end
            end
        end
    end

    // High byte comes first, its upper nibble is not part of the angle and shifts out
    always_ff @(posedge PHASE1) begin
        if (((state == servo_pkg::DATA0) || (state == servo_pkg::DATA1)) &&
            (quarter == 2'd2)) begin
            data_sr <= {data_sr[10:0], sda};
        end
    end

    assign sample = data_sr;

    always_comb begin
        state_next = state;
        case (state)
            servo_pkg::IDLE:      state_next = angle_done ? servo_pkg::IDLE : servo_pkg::START;
            servo_pkg::START:     state_next = servo_pkg::DEV_WR;
            servo_pkg::DEV_WR:    state_next = (bit_cnt == 3'd7) ? servo_pkg::ACK0 : state;
            servo_pkg::ACK0:      state_next = ack_fail ? servo_pkg::ABORT : servo_pkg::READ_ADDR;
            servo_pkg::READ_ADDR: state_next = (bit_cnt == 3'd7) ? servo_pkg::ACK1 : state;
            servo_pkg::ACK1:      state_next = ack_fail ? servo_pkg::ABORT : servo_pkg::REP_START;
            servo_pkg::REP_START: state_next = servo_pkg::DEV_RD;
            servo_pkg::DEV_RD:    state_next = (bit_cnt == 3'd7) ? servo_pkg::ACK2 : state;
            servo_pkg::ACK2:      state_next = ack_fail ? servo_pkg::ABORT : servo_pkg::DATA0;
            servo_pkg::DATA0:     state_next = (bit_cnt == 3'd7) ? servo_pkg::ACK3 : state;
            servo_pkg::ACK3:      state_next = servo_pkg::DATA1;
            servo_pkg::DATA1:     state_next = (bit_cnt == 3'd7) ? servo_pkg::NACK : state;
            servo_pkg::NACK:      state_next = servo_pkg::STOP;
            servo_pkg::STOP:      state_next = servo_pkg::PAUSE;
            servo_pkg::ABORT:     state_next = servo_pkg::PAUSE;
            servo_pkg::PAUSE:     state_next = angle_done ? servo_pkg::IDLE : servo_pkg::START;
            default:              state_next = servo_pkg::IDLE;
        endcase
    end

    always_comb begin
        case (state)
            servo_pkg::DEV_WR:    tx_byte = `SERVO_ENC_WRITE_ADDR;
            servo_pkg::READ_ADDR: tx_byte = `SERVO_RAW_ANGLE_REG;
            servo_pkg::DEV_RD:    tx_byte = `SERVO_ENC_READ_ADDR;
            default:              tx_byte = 8'hFF;
        endcase
    end

    assign tx_bit = tx_byte[3'd7 - bit_cnt];   // MSB first

    // SCL is low in quarters 0 and 1 and high in 2 and 3 of every bus slot
    always_comb begin
        scl     = 1'b1;
        sda_low = 1'b0;
        case (state)
            servo_pkg::START: begin
                scl     = (quarter != 2'd3);
                sda_low = (quarter != 2'd0);   // SDA falls while SCL is high
            end
            servo_pkg::DEV_WR, servo_pkg::READ_ADDR, servo_pkg::DEV_RD: begin
                scl     = quarter[1];
                sda_low = !tx_bit;
            end
            servo_pkg::ACK3: begin
                scl     = quarter[1];
                sda_low = 1'b1;   // Master ACK after the high byte
            end
            servo_pkg::REP_START: begin
                scl     = quarter[1];
                sda_low = (quarter == 2'd0) || (quarter == 2'd3);
            end
            servo_pkg::STOP, servo_pkg::ABORT: begin
                scl     = quarter[1];
                sda_low = (quarter == 2'd1) || (quarter == 2'd2);   // Rises while SCL is high
            end
            servo_pkg::ACK0, servo_pkg::ACK1, servo_pkg::ACK2,
            servo_pkg::DATA0, servo_pkg::DATA1, servo_pkg::NACK: begin
                scl = quarter[1];
            end
            default: begin
                scl     = 1'b1;
                sda_low = 1'b0;
            end
        endcase
    end

    assign sda = sda_low ? 1'b0 : 1'bz;

endmodule

// File: hdl/angle_fifo.sv
/* Angle sample FIFO between the I2C reader and the position controller
   A push into a full FIFO is dropped unless a pop frees a slot in the same cycle */
`timescale 1ns/100ps
`include "servo_settings.svh"

module angle_fifo #(
    parameter int DEPTH = `SERVO_FIFO_DEPTH
) (
    input  logic              PHASE1,
    input  logic              reset_n,
    input  logic              push,
    input  servo_pkg::angle_t push_data,
    input  logic              pop,
    output servo_pkg::angle_t head,
    output logic              empty,
    output logic [7:0]        overflow_count
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    servo_pkg::angle_t mem [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             do_push;
    logic             do_pop;

    assign empty   = (count == '0);
    assign full    = (count == CNT_W'(DEPTH));
    assign do_pop  = pop && !empty;
    assign do_push = push && (!full || do_pop);
    assign head    = mem[rd_ptr];

    always_ff @(posedge PHASE1) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge PHASE1 or negedge reset_n) begin
        if (!reset_n) begin
            rd_ptr         <= '0;
            wr_ptr         <= '0;
            count          <= '0;
            overflow_count <= 8'd0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
            if (push && !do_push && (overflow_count != 8'hFF)) begin
                overflow_count <= overflow_count + 8'd1;   // Saturates at 255
            end
        end
    end

endmodule

// File: hdl/pwm_position_ctrl.sv
/* Proportional position controller with PWM and direction outputs
   The error wraps at the 0/4095 seam so the motor turns the shorter way */
`timescale 1ns/100ps
`include "servo_settings.svh"

module pwm_position_ctrl (
    input  logic              PHASE1,
    input  logic              reset_n,
    input  servo_pkg::angle_t target_angle,
    input  servo_pkg::angle_t head,
    input  logic              empty,
    output logic              pop,
    output servo_pkg::angle_t current_angle,
    output logic              angle_done,
    output logic              motor_dir,
    output logic              pwm_out
);

    localparam int CNT_W = $clog2(`SERVO_PWM_PERIOD);

    logic [11:0]           diff;
    servo_pkg::angle_err_t err;
    logic [11:0]           abs_err;
    logic [11:0]           duty_raw;
    logic                  at_target;
    servo_pkg::duty_t      duty_calc;
    servo_pkg::duty_t      duty_q;
    servo_pkg::duty_t      duty_active;
    logic [CNT_W-1:0]      period_cnt;

    // Take every sample as soon as the FIFO shows one
    assign pop = !empty;

    // Difference modulo one turn, read as a signed value from -2048 to +2047
    assign diff    = target_angle - head;
    assign err     = {diff[11], diff};
    assign abs_err = err[12] ? (12'd0 - diff) : diff;

    assign at_target = (abs_err <= 12'(`SERVO_ANGLE_TOL));
    assign duty_raw  = abs_err >> `SERVO_DUTY_SHIFT;

    always_comb begin
        if (at_target) begin
            duty_calc = '0;
        end else if (duty_raw > 12'(`SERVO_PWM_PERIOD)) begin
            duty_calc = servo_pkg::duty_t'(`SERVO_PWM_PERIOD);
        end else begin
            duty_calc = duty_raw[6:0];
        end
    end

    always_ff @(posedge PHASE1 or negedge reset_n) begin
        if (!reset_n) begin
            current_angle <= '0;
            angle_done    <= 1'b0;   // Low so the reader starts right after reset
            motor_dir     <= 1'b0;
            duty_q        <= '0;
        end else if (pop) begin
            current_angle <= head;
            angle_done    <= at_target;
            motor_dir     <= !err[12] && (err != '0);
            duty_q        <= duty_calc;
        end
    end

    // A new duty only takes hold at the start of a period
    always_ff @(posedge PHASE1 or negedge reset_n) begin
        if (!reset_n) begin
            period_cnt  <= '0;
            duty_active <= '0;
        end else if (period_cnt == CNT_W'(`SERVO_PWM_PERIOD - 1)) begin
            period_cnt  <= '0;
            duty_active <= duty_q;
        end else begin
            period_cnt <= period_cnt + 1'b1;
        end
    end

    assign pwm_out = (servo_pkg::duty_t'(period_cnt) < duty_active);

endmodule

// File: hdl/servo_top.sv
/* Servo position loop: AS5600 reader, angle FIFO and PWM controller
   sda needs a pull-up outside the block */
`timescale 1ns/100ps
`include "servo_settings.svh"

module servo_top (
    input  logic              PHASE1,
    input  logic              reset_n,
    input  servo_pkg::angle_t target_angle,
    output logic              scl,
    inout  wire               sda,
    output logic              pwm_out,
    output logic              motor_dir,
    output logic              angle_done,
    output logic              i2c_error,
    output servo_pkg::angle_t current_angle,
    output logic [7:0]        overflow_count
);

    servo_pkg::angle_t sample;
    servo_pkg::angle_t head;
    logic              rd_done;
    logic              empty;
    logic              pop;

    as5600_reader as5600_reader_inst (
        .PHASE1     (PHASE1),
        .reset_n    (reset_n),
        .angle_done (angle_done),
        .sample     (sample),
        .rd_done    (rd_done),
        .i2c_error  (i2c_error),
        .scl        (scl),
        .sda        (sda)
    );

    angle_fifo #(
        .DEPTH (`SERVO_FIFO_DEPTH)
    ) angle_fifo_inst (
        .PHASE1         (PHASE1),
        .reset_n        (reset_n),
        .push           (rd_done),
        .push_data      (sample),
        .pop            (pop),
        .head           (head),
        .empty          (empty),
        .overflow_count (overflow_count)
    );

    pwm_position_ctrl pwm_position_ctrl_inst (
        .PHASE1        (PHASE1),
        .reset_n       (reset_n),
        .target_angle  (target_angle),
        .head          (head),
        .empty         (empty),
        .pop           (pop),
        .current_angle (current_angle),
        .angle_done    (angle_done),
        .motor_dir     (motor_dir),
        .pwm_out       (pwm_out)
    );

endmodule

// File: tb/tb_clock_gen.sv
/* PHASE1 with a 100 ns period, reset_n held low for the first 16 cycles */
`timescale 1ns/100ps

module tb_clock_gen (
    output logic PHASE1,
    output logic reset_n
);

    initial begin
        PHASE1  = 1'b0;
        reset_n = 1'b0;
        repeat (16) @(posedge PHASE1);
        reset_n <= 1'b1;
    end

    always #50 PHASE1 = ~PHASE1;

endmodule

// File: tb/as5600_model.sv
/* Behavioral AS5600 target, samples the bus on the falling edge of PHASE1
   Only the raw angle read is modeled, a byte other than the expected address or pointer gets no ACK */
`timescale 1ns/100ps
`include "servo_settings.svh"

module as5600_model (
    input  logic              PHASE1,
    input  logic              reset_n,
    input  logic              scl,
    inout  wire               sda,
    input  servo_pkg::angle_t angle,
    input  logic              withhold_ack,
    output int                reads_done
);

    servo_pkg::i2c_state_e phase;
    logic        drive_low;
    logic        prev_scl;
    logic        prev_sda;
    logic        read_mode;
    logic        master_nack;
    logic        data_sent;
    logic [7:0]  rx_byte;
    logic [7:0]  expected_byte;
    logic [15:0] tx_word;
    int          bit_cnt;
    int          tx_idx;
    int          byte_idx;

    assign sda = drive_low ? 1'b0 : 1'bz;

    // Device write address, then the pointer, then the device read address after repeated START
    always_comb begin
        case (byte_idx)
            0:       expected_byte = `SERVO_ENC_WRITE_ADDR;
            1:       expected_byte = `SERVO_RAW_ANGLE_REG;
            default: expected_byte = `SERVO_ENC_READ_ADDR;
        endcase
    end

    always @(negedge PHASE1 or negedge reset_n) begin
        if (!reset_n) begin
            phase      <= servo_pkg::IDLE;
            drive_low  <= 1'b0;
            prev_scl   <= 1'b1;
            prev_sda   <= 1'b1;
            data_sent  <= 1'b0;
            reads_done <= 0;
        end else begin
            prev_scl <= scl;
            prev_sda <= sda;
            if (scl && prev_scl && (sda == 1'b0) && prev_sda) begin   // START or repeated START
                phase     <= servo_pkg::DEV_WR;
                bit_cnt   <= 0;
                byte_idx  <= (phase == servo_pkg::IDLE) ? 0 : byte_idx;
                drive_low <= 1'b0;
            end else if (scl && prev_scl && sda && !prev_sda) begin   // STOP
                if (data_sent) begin
                    reads_done <= reads_done + 1;
                end
                data_sent <= 1'b0;
                phase     <= servo_pkg::IDLE;
                drive_low <= 1'b0;
            end else if (scl && !prev_scl) begin
                if (phase == servo_pkg::DEV_WR) begin
                    rx_byte <= {rx_byte[6:0], sda};
                    bit_cnt <= bit_cnt + 1;
                end else if (phase == servo_pkg::DATA0) begin
                    bit_cnt <= bit_cnt + 1;
                    tx_idx  <= tx_idx + 1;
                end else if (phase == servo_pkg::ACK3) begin
                    master_nack <= sda;
                end
            end else if (!scl && prev_scl) begin
                case (phase)
                    servo_pkg::DEV_WR: begin
                        if (bit_cnt == 8) begin
                            if (rx_byte == `SERVO_ENC_READ_ADDR) begin
                                read_mode <= 1'b1;
                            end else begin
                                read_mode <= 1'b0;
                            end
                            if ((rx_byte == expected_byte) && !withhold_ack) begin
                                drive_low <= 1'b1;
                                phase     <= servo_pkg::ACK0;
                            end else begin
                                phase <= servo_pkg::IDLE;   // No ACK, the master aborts
                            end
                        end
                    end
                    servo_pkg::ACK0: begin
                        byte_idx <= byte_idx + 1;
                        bit_cnt  <= 0;
                        if (read_mode) begin
                            tx_word   <= {4'h0, angle};
                            tx_idx    <= 0;
                            drive_low <= 1'b1;   // High nibble of the first byte is zero
                            phase     <= servo_pkg::DATA0;
                        end else begin
                            drive_low <= 1'b0;
                            phase     <= servo_pkg::DEV_WR;
                        end
                    end
                    servo_pkg::DATA0: begin
                        if (bit_cnt == 8) begin
                            drive_low <= 1'b0;
                            bit_cnt   <= 0;
                            phase     <= servo_pkg::ACK3;
                        end else begin
                            drive_low <= !tx_word[15 - tx_idx];
                        end
                    end
                    servo_pkg::ACK3: begin
                        if (master_nack) begin
                            data_sent <= 1'b1;
                            phase     <= servo_pkg::IDLE;
                        end else begin
                            drive_low <= !tx_word[15 - tx_idx];
                            phase     <= servo_pkg::DATA0;
                        end
                    end
                    default: drive_low <= 1'b0;
                endcase
            end
        end
    end

endmodule

// File: tb/tb_servo_top.sv
/* Testbench for servo_top with a behavioral AS5600 and a reference model of the controller
   Every test case restarts the DUT so each update comes from a fresh encoder read */
`timescale 1ns/100ps
`include "servo_settings.svh"

module tb_servo_top;

    logic              PHASE1;
    logic              reset_n;
    logic              soft_rst_n;
    logic              dut_rst_n;
    servo_pkg::angle_t target_angle;
    servo_pkg::angle_t enc_angle;
    logic              withhold_ack;
    wire               sda;
    logic              scl;
    logic              pwm_out;
    logic              motor_dir;
    logic              angle_done;
    logic              i2c_error;
    servo_pkg::angle_t current_angle;
    logic [7:0]        overflow_count;
    int                reads_done;
    int                errors;
    int                tests_passed;
    int                tests_failed;

    pullup (sda);
    assign dut_rst_n = reset_n && soft_rst_n;

    tb_clock_gen tb_clock_gen_inst (.PHASE1(PHASE1), .reset_n(reset_n));

    as5600_model as5600_model_inst (
        .PHASE1(PHASE1), .reset_n(dut_rst_n), .scl(scl), .sda(sda),
        .angle(enc_angle), .withhold_ack(withhold_ack), .reads_done(reads_done)
    );

    servo_top servo_top_inst (
        .PHASE1(PHASE1), .reset_n(dut_rst_n), .target_angle(target_angle),
        .scl(scl), .sda(sda), .pwm_out(pwm_out), .motor_dir(motor_dir),
        .angle_done(angle_done), .i2c_error(i2c_error),
        .current_angle(current_angle), .overflow_count(overflow_count)
    );

    // Target minus measured, taken the shorter way round the turn
    function automatic int wrapped_error(int tgt, int enc);
        int d;
        d = (tgt - enc) & 4095;
        if (d >= 2048) begin
            d = d - 4096;
        end
        return d;
    endfunction

    function automatic int expected_duty(int err);
        int a;
        a = (err < 0) ? -err : err;
        if (a <= `SERVO_ANGLE_TOL) begin
            return 0;
        end
        a = a >> `SERVO_DUTY_SHIFT;
        return (a > `SERVO_PWM_PERIOD) ? `SERVO_PWM_PERIOD : a;
    endfunction

    task automatic check_value(string name, int expected, int actual);
        if (expected != actual) begin
            $display("[ERROR] %0t ns: %s expected %0d, got %0d", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic finish_test(string name);
        if (errors == 0) begin
            tests_passed++;
            $display("PASS %s", name);
        end else begin
            tests_failed++;
            $display("FAIL %s (%0d errors)", name, errors);
        end
        errors = 0;
    endtask

    task automatic restart_with(int tgt, int enc, logic no_ack);
        @(posedge PHASE1);
        target_angle <= servo_pkg::angle_t'(tgt);
        enc_angle    <= servo_pkg::angle_t'(enc);
        withhold_ack <= no_ack;
        soft_rst_n   <= 1'b0;
        repeat (2) @(posedge PHASE1);
        soft_rst_n <= 1'b1;
        @(posedge PHASE1);
    endtask

    // Waits for the model to finish a read, then lets it pass through FIFO and controller
    task automatic wait_for_update();
        int c0;
        int n;
        c0 = reads_done;
        n  = 0;
        while (reads_done == c0 && n < 600) begin
            @(negedge PHASE1);
            n++;
        end
        if (reads_done == c0) begin
            $display("Timeout at %0t ns: no encoder read completed in 600 cycles", $time);
            errors++;
        end else begin
            repeat (8) @(negedge PHASE1);
            check_value("overflow_count", 0, overflow_count);   // Every sample is popped at once
        end
    endtask

    task automatic readback_test();
        int enc;
        for (int i = 0; i < 20; i++) begin
            enc = $urandom % 4096;
            restart_with(enc ^ 12'h800, enc, 1'b0);
            wait_for_update();
            check_value("current_angle", enc, current_angle);
        end
        finish_test("angle readback");
    endtask

    task automatic direction_test();
        int enc;
        int tgt;
        int err;
        for (int i = 0; i < 16; i++) begin
            case (i % 4)
                0: begin
                    enc = $urandom % 4096;
                    tgt = $urandom % 4096;
                end
                1: begin
                    enc = $urandom % 32;
                    tgt = 4095 - ($urandom % 32);
                end
                2: begin
                    enc = 4095 - ($urandom % 32);
                    tgt = $urandom % 32;
                end
                default: begin
                    enc = $urandom % 4096;
                    tgt = (enc + ($urandom % 25) - 12) & 4095;
                end
            endcase
            err = wrapped_error(tgt, enc);
            restart_with(tgt, enc, 1'b0);
            wait_for_update();
            check_value("motor_dir", (err > 0) ? 1 : 0, motor_dir);
            check_value("angle_done",
                        (err <= `SERVO_ANGLE_TOL && err >= -`SERVO_ANGLE_TOL) ? 1 : 0,
                        angle_done);
        end
        finish_test("error and direction");
    endtask

    task automatic duty_test();
        int enc;
        int mag;
        int tgt;
        int cnt;
        logic prev;
        logic found;
        for (int i = 0; i < 10; i++) begin
            enc = $urandom % 4096;
            mag = (i < 5) ? (9 + $urandom % 200) : (9 + $urandom % 2039);
            tgt = ($urandom % 2) ? ((enc + mag) & 4095) : ((enc - mag) & 4095);
            restart_with(tgt, enc, 1'b0);
            wait_for_update();
            repeat (70) @(negedge PHASE1);   // New duty is active from the next period start
            found = 1'b0;
            prev  = pwm_out;
            for (int n = 0; n < 128 && !found; n++) begin
                @(negedge PHASE1);
                found = pwm_out && !prev;
                prev  = pwm_out;
            end
            cnt = found ? 1 : (prev ? `SERVO_PWM_PERIOD : 0);
            if (found) begin
                for (int n = 1; n < `SERVO_PWM_PERIOD; n++) begin
                    @(negedge PHASE1);
                    cnt += pwm_out;
                end
            end
            check_value("pwm_out high cycles", expected_duty(wrapped_error(tgt, enc)), cnt);
        end
        finish_test("PWM duty");
    endtask

    task automatic hold_test();
        int enc;
        int toggles;
        logic last_scl;
        enc = $urandom % 4096;
        restart_with((enc + ($urandom % 17) - 8) & 4095, enc, 1'b0);
        wait_for_update();
        check_value("angle_done", 1, angle_done);
        toggles  = 0;
        last_scl = scl;
        for (int n = 0; n < 1000; n++) begin
            @(negedge PHASE1);
            toggles += (scl != last_scl);
            last_scl = scl;
            check_value("pwm_out", 0, pwm_out);
            check_value("angle_done", 1, angle_done);
        end
        check_value("scl toggles", 0, toggles);
        finish_test("hold at target");
    endtask

    task automatic missing_ack_test();
        int enc;
        int n;
        enc = ($urandom % 4096) | 1;
        restart_with(enc ^ 12'h800, enc, 1'b1);
        n = 0;
        while (!i2c_error && n < 600) begin
            @(negedge PHASE1);
            n++;
        end
        if (!i2c_error) begin
            $display("Timeout at %0t ns: i2c_error did not pulse within 600 cycles", $time);
            errors++;
        end
        // No sample may reach the controller while the encoder stays silent
        n = 0;
        while (current_angle == 0 && n < 600) begin
            @(negedge PHASE1);
            n++;
        end
        check_value("current_angle", 0, current_angle);
        @(posedge PHASE1);
        withhold_ack <= 1'b0;
        wait_for_update();
        check_value("current_angle", enc, current_angle);
        finish_test("missing ACK");
    endtask

    initial begin
        int n;
        void'($urandom(56));
        soft_rst_n   = 1'b1;
        target_angle = '0;
        enc_angle    = '0;
        withhold_ack = 1'b0;
        errors       = 0;
        tests_passed = 0;
        tests_failed = 0;
        n = 0;
        while (!reset_n && n < 100) begin
            @(posedge PHASE1);
            n++;
        end
        if (!reset_n) begin
            $display("Timeout: reset_n was never released");
            tests_failed++;
        end else begin
            readback_test();
            direction_test();
            duty_test();
            hold_test();
            missing_ack_test();
        end
        $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+include
hdl/servo_pkg.sv
hdl/as5600_reader.sv
hdl/angle_fifo.sv
hdl/pwm_position_ctrl.sv
hdl/servo_top.sv
tb/tb_clock_gen.sv
tb/as5600_model.sv
tb/tb_servo_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the servo testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    -f verilog.f \
    --top-module tb_servo_top \
    -o sim_servo

./obj_dir/sim_servo | tee sim.log

if grep -q "Verification passed" sim.log; then
    exit 0
else
    exit 1
fi
